// ==== verilog/f2_pkg.sv ====
package f2_pkg;

////////////////////////////////////////
// Bus widths

localparam int CPU_ADDR_W = 23;
localparam int SDR_ADDR_W = 27;

////////////////////////////////////////
// Memory map, byte addresses

localparam logic [CPU_ADDR_W:0] ROM_BASE  = 24'h000000;
localparam logic [CPU_ADDR_W:0] ROM_MASK  = 24'hf00000;
localparam logic [CPU_ADDR_W:0] WORK_BASE = 24'h100000;
localparam logic [CPU_ADDR_W:0] WORK_MASK = 24'hff0000;

// 4096 palette words
localparam int                  PAL_ADDR_W = 12;
localparam logic [CPU_ADDR_W:0] PAL_BASE   = 24'h200000;

// 8 input port words
localparam int                  IO_ADDR_W = 3;
localparam logic [CPU_ADDR_W:0] IO_BASE   = 24'h300000;

// Interrupt levels
localparam logic [2:0] VBL_LEVEL = 3'd5;
localparam logic [2:0] DMA_LEVEL = 3'd6;

// RGB555 palette entry, seen as a bus word or as colour fields
typedef union packed {
    logic [15:0] raw;
    struct packed {
        logic       unused;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } f;
} palette_word_t;

endpackage

// ==== verilog/io_ports.sv ====
`timescale 1ns/1ps

module io_ports import f2_pkg::*; (
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [7:0]            joystick_p1,
    input  logic [7:0]            joystick_p2,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,
    input  logic [7:0]            dswa,
    input  logic [7:0]            dswb,
    output logic [15:0]           io_q
);

logic [7:0] port_byte;

// Start, buttons 6..4, then directions in reverse bit order
function automatic logic [7:0] player_byte(input logic [7:0] joy, input logic st);
    return {st, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
endfunction

always_comb begin
    case (cpu_addr[IO_ADDR_W-1:0])
        3'd0:    port_byte = dswa;
        3'd1:    port_byte = dswb;
        3'd2:    port_byte = player_byte(joystick_p1, start[0]);
        3'd3:    port_byte = player_byte(joystick_p2, start[1]);
        3'd4:    port_byte = {4'b0000, coin, 2'b00};
        default: port_byte = 8'h00;
    endcase
end

// Inputs are active low on the board
assign io_q = {8'h00, ~port_byte};

endmodule

// ==== verilog/interrupt_ctrl.sv ====
`timescale 1ns/1ps

module interrupt_ctrl import f2_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  vblank_n,
    input  logic                  dma_n,

    input  logic                  iack,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,

    output logic [2:0]            ipl_n
);

logic vbl_prev;
logic dma_prev;
logic vbl_pend;
logic dma_pend;
logic clr_vbl;
logic clr_dma;

assign clr_vbl = iack & ~cpu_ds_n[0] & (cpu_addr[2:0] == VBL_LEVEL);
assign clr_dma = iack & ~cpu_ds_n[0] & (cpu_addr[2:0] == DMA_LEVEL);

// Input levels from the previous clock
always_ff @(posedge clk) begin
    vbl_prev <= vblank_n;
    dma_prev <= dma_n;
end

always_ff @(posedge clk) begin
    if (reset) begin
        vbl_pend <= 1'b0;
        dma_pend <= 1'b0;
    end else begin
        // VBL on falling edge, DMA end on rising edge
        if (vbl_prev & ~vblank_n) vbl_pend <= 1'b1;
        if (~dma_prev & dma_n) dma_pend <= 1'b1;

        if (clr_vbl) vbl_pend <= 1'b0;
        if (clr_dma) dma_pend <= 1'b0;
    end
end

assign ipl_n = dma_pend ? ~DMA_LEVEL :
               vbl_pend ? ~VBL_LEVEL :
               3'b111;

endmodule

// ==== verilog/palette.sv ====
`timescale 1ns/1ps

module palette import f2_pkg::*; (
    input  logic                  clk,

    input  logic                  pal_sel,
    input  logic                  cycle_start,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,
    input  logic                  cpu_rw,
    input  logic [15:0]           cpu_dout,
    output logic [15:0]           pal_q,
    output logic                  pal_busy,

    input  logic                  ce_pixel,
    input  logic [PAL_ADDR_W-1:0] pixel_index,
    output logic [7:0]            red,
    output logic [7:0]            green,
    output logic [7:0]            blue
);

logic [15:0]           ram [0:(1 << PAL_ADDR_W) - 1];
logic [PAL_ADDR_W-1:0] cpu_index;
logic                  cpu_we;
palette_word_t         pix_word;

// 5 bits on top, top 3 repeated below
function automatic logic [7:0] expand5(input logic [4:0] c);
    return {c, c[4:2]};
endfunction

assign cpu_index = cpu_addr[PAL_ADDR_W-1:0];
assign cpu_we    = cycle_start & pal_sel & ~cpu_rw;

////////////////////////////////////////
// CPU port

always_ff @(posedge clk) begin
    if (cpu_we & ~cpu_ds_n[1]) ram[cpu_index][15:8] <= cpu_dout[15:8];
    if (cpu_we & ~cpu_ds_n[0]) ram[cpu_index][7:0] <= cpu_dout[7:0];
    pal_q <= ram[cpu_index];
end

// Read data lands one clock after the start
assign pal_busy = cycle_start & pal_sel & cpu_rw;

////////////////////////////////////////
// Pixel port

always_ff @(posedge clk) begin
    if (ce_pixel) begin
        pix_word.raw <= ram[pixel_index];
    end
    red   <= expand5(pix_word.f.red);
    green <= expand5(pix_word.f.green);
    blue  <= expand5(pix_word.f.blue);
end

endmodule

// ==== verilog/sdram_bridge.sv ====
`timescale 1ns/1ps

module sdram_bridge import f2_pkg::*; #(
    parameter logic [SDR_ADDR_W-1:0] CPU_ROM_SDR_BASE  = '0,
    parameter logic [SDR_ADDR_W-1:0] WORK_RAM_SDR_BASE = '0
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  cycle_start,
    input  logic                  rom_sel,
    input  logic                  work_sel,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,
    input  logic                  cpu_rw,
    input  logic [15:0]           cpu_dout,

    output logic [SDR_ADDR_W-1:0] sdr_addr,
    output logic [15:0]           sdr_data,
    output logic [1:0]            sdr_be,
    output logic                  sdr_rw,
    output logic                  sdr_req,
    input  logic                  sdr_ack,

    output logic                  sdr_busy
);

localparam int PAD_W = SDR_ADDR_W - CPU_ADDR_W - 1;

logic [CPU_ADDR_W:0] byte_addr;
logic                start_req;

assign byte_addr = {cpu_addr, 1'b0};
assign start_req = cycle_start & (rom_sel | work_sel);

always_ff @(posedge clk) begin
    if (reset) begin
        sdr_req <= 1'b0;
    end else if (start_req) begin
        sdr_req <= ~sdr_req;
    end
end

// Request payload, held until the next start
always_ff @(posedge clk) begin
    if (cycle_start & rom_sel) begin
        sdr_addr <= CPU_ROM_SDR_BASE + {{PAD_W{1'b0}}, byte_addr & ~ROM_MASK};
        sdr_rw   <= 1'b1;
        sdr_be   <= ~cpu_ds_n;
    end else if (cycle_start & work_sel) begin
        sdr_addr <= WORK_RAM_SDR_BASE + {{PAD_W{1'b0}}, byte_addr & ~WORK_MASK};
        sdr_rw   <= cpu_rw;
        sdr_be   <= ~cpu_ds_n;
        sdr_data <= cpu_dout;
    end
end

// Busy from the start cycle until the ack catches up
assign sdr_busy = start_req | (sdr_req != sdr_ack);

endmodule

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import f2_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,
    input  logic                  cpu_rw,
    input  logic [2:0]            cpu_fc,

    input  logic [15:0]           sdr_q,
    input  logic                  sdr_busy,
    input  logic [15:0]           pal_q,
    input  logic                  pal_busy,
    input  logic [15:0]           io_q,

    output logic                  rom_sel,
    output logic                  work_sel,
    output logic                  pal_sel,
    output logic                  io_sel,
    output logic                  iack,
    output logic                  cycle_start,
    output logic [15:0]           cpu_din,
    output logic                  dtack_n
);

logic [CPU_ADDR_W:0] byte_addr;
logic                strobe;
logic                idle_prev;
logic                mem_cycle;

assign byte_addr = {cpu_addr, 1'b0};
assign strobe    = ~&cpu_ds_n;

////////////////////////////////////////
// Cycle start

always_ff @(posedge clk) begin
    if (reset) begin
        idle_prev <= 1'b0;
    end else begin
        idle_prev <= ~strobe;
    end
end

assign cycle_start = idle_prev & strobe;

////////////////////////////////////////
// Chip selects

// FC 7 is an acknowledge cycle and hits no region
assign iack      = strobe & (cpu_fc == 3'b111);
assign mem_cycle = strobe & ~iack;

assign rom_sel  = mem_cycle & ((byte_addr & ROM_MASK) == ROM_BASE);
assign work_sel = mem_cycle & ((byte_addr & WORK_MASK) == WORK_BASE);
assign pal_sel  = mem_cycle &
    (byte_addr[CPU_ADDR_W:PAL_ADDR_W+1] == PAL_BASE[CPU_ADDR_W:PAL_ADDR_W+1]);
assign io_sel   = mem_cycle &
    (byte_addr[CPU_ADDR_W:IO_ADDR_W+1] == IO_BASE[CPU_ADDR_W:IO_ADDR_W+1]);

////////////////////////////////////////
// Read data and DTACK

always_comb begin
    if (!cpu_rw) begin
        cpu_din = 16'h0000;
    end else if (rom_sel | work_sel) begin
        cpu_din = sdr_q;
    end else if (pal_sel) begin
        cpu_din = pal_q;
    end else if (io_sel) begin
        cpu_din = io_q;
    end else begin
        cpu_din = 16'h0000;
    end
end

// Unmapped and acknowledge cycles end at once
assign dtack_n = ~strobe | sdr_busy | pal_busy;

endmodule

// ==== verilog/f2_main_bus.sv ====
`timescale 1ns/1ps

module f2_main_bus import f2_pkg::*; #(
    parameter logic [SDR_ADDR_W-1:0] CPU_ROM_SDR_BASE  = '0,
    parameter logic [SDR_ADDR_W-1:0] WORK_RAM_SDR_BASE = '0
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,
    input  logic                  cpu_rw,
    input  logic [2:0]            cpu_fc,
    input  logic [15:0]           cpu_dout,
    output logic [15:0]           cpu_din,
    output logic                  dtack_n,
    output logic [2:0]            ipl_n,

    output logic [SDR_ADDR_W-1:0] sdr_addr,
    output logic [15:0]           sdr_data,
    output logic [1:0]            sdr_be,
    output logic                  sdr_rw,
    output logic                  sdr_req,
    input  logic [15:0]           sdr_q,
    input  logic                  sdr_ack,

    input  logic                  ce_pixel,
    input  logic [PAL_ADDR_W-1:0] pixel_index,
    input  logic                  vblank_n,
    input  logic                  dma_n,
    output logic [7:0]            red,
    output logic [7:0]            green,
    output logic [7:0]            blue,

    input  logic [7:0]            joystick_p1,
    input  logic [7:0]            joystick_p2,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,
    input  logic [7:0]            dswa,
    input  logic [7:0]            dswb
);

logic        rom_sel, work_sel, pal_sel, io_sel;
logic        iack, cycle_start;
logic        sdr_busy, pal_busy;
logic [15:0] pal_q, io_q;

bus_decoder i_bus_decoder (
    .clk, .reset, .cpu_addr, .cpu_ds_n, .cpu_rw, .cpu_fc,
    .sdr_q, .sdr_busy, .pal_q, .pal_busy, .io_q,
    .rom_sel, .work_sel, .pal_sel, .io_sel, .iack, .cycle_start,
    .cpu_din, .dtack_n
);

sdram_bridge #(
    .CPU_ROM_SDR_BASE  (CPU_ROM_SDR_BASE),
    .WORK_RAM_SDR_BASE (WORK_RAM_SDR_BASE)
) i_sdram_bridge (
    .clk, .reset, .cycle_start, .rom_sel, .work_sel,
    .cpu_addr, .cpu_ds_n, .cpu_rw, .cpu_dout,
    .sdr_addr, .sdr_data, .sdr_be, .sdr_rw, .sdr_req, .sdr_ack, .sdr_busy
);

interrupt_ctrl i_interrupt_ctrl (
    .clk, .reset, .vblank_n, .dma_n, .iack, .cpu_addr, .cpu_ds_n, .ipl_n
);

palette i_palette (
    .clk, .pal_sel, .cycle_start, .cpu_addr, .cpu_ds_n, .cpu_rw, .cpu_dout,
    .pal_q, .pal_busy, .ce_pixel, .pixel_index, .red, .green, .blue
);

io_ports i_io_ports (
    .cpu_addr, .joystick_p1, .joystick_p2, .start, .coin, .dswa, .dswb, .io_q
);

endmodule

// ==== verification/f2_asserts.sv ====
`timescale 1ns/1ps

module f2_asserts import f2_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sdr_req,
    input  logic                  sdr_ack,
    input  logic [SDR_ADDR_W-1:0] sdr_addr,
    input  logic [2:0]            ipl_n
);

// New request only once the previous one is acknowledged
req_toggle: assert property (@(posedge clk) disable iff (reset)
    $changed(sdr_req) |-> $past(sdr_req == sdr_ack))
    else $error("sdr_req toggled while a request was pending");

addr_stable: assert property (@(posedge clk) disable iff (reset)
    (sdr_req != sdr_ack) && $past(sdr_req != sdr_ack) |-> $stable(sdr_addr))
    else $error("sdr_addr changed during a pending request");

// Only levels 5 and 6 exist
ipl_level: assert property (@(posedge clk) disable iff (reset)
    ipl_n inside {3'b111, 3'b010, 3'b001})
    else $error("ipl_n carries a level that is never raised");

endmodule

// ==== verification/f2_checker.sv ====
`timescale 1ns/1ps

module f2_checker import f2_pkg::*; #(
    parameter logic [SDR_ADDR_W-1:0] ROM_SDR  = '0,
    parameter logic [SDR_ADDR_W-1:0] WORK_SDR = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  logic [1:0]            cpu_ds_n,
    input  logic                  cpu_rw,
    input  logic [2:0]            cpu_fc,
    input  logic [15:0]           cpu_dout,
    input  logic [15:0]           cpu_din,
    input  logic                  dtack_n,
    input  logic [2:0]            ipl_n,
    input  logic [SDR_ADDR_W-1:0] sdr_addr,
    input  logic [15:0]           sdr_data,
    input  logic [1:0]            sdr_be,
    input  logic                  sdr_rw,
    input  logic                  sdr_req,
    input  logic                  ce_pixel,
    input  logic [PAL_ADDR_W-1:0] pixel_index,
    input  logic                  vblank_n,
    input  logic                  dma_n,
    input  logic [7:0]            red,
    input  logic [7:0]            green,
    input  logic [7:0]            blue,
    input  logic [7:0]            joystick_p1,
    input  logic [7:0]            joystick_p2,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,
    input  logic [7:0]            dswa,
    input  logic [7:0]            dswb,
    output int                    checks,
    output int                    errors
);

logic [15:0]   work_model [int];
palette_word_t pal_model [int];

logic        in_cycle;
logic        done;
logic        was_sdram;
logic        req_last;
int          toggles;
int          toggles_start;
logic        vbl_prev;
logic        dma_prev;
logic        vbl_pend;
logic        dma_pend;
logic        pix1_valid;
logic        pix2_valid;
logic [23:0] pix1_rgb;
logic [23:0] pix2_rgb;

initial begin
    checks = 0;
    errors = 0;
end

task automatic check_value(input string what, input logic [31:0] exp,
                           input logic [31:0] got);
    checks++;
    if (exp !== got) begin
        errors++;
        $display("error %0t: %s expected %h got %h", $time, what, exp, got);
    end
endtask

function automatic logic [15:0] merge(input logic [15:0] old_w, input logic [15:0] new_w,
                                      input logic [1:0] ds_n);
    logic [15:0] w;
    w = old_w;
    if (!ds_n[1]) w[15:8] = new_w[15:8];
    if (!ds_n[0]) w[7:0] = new_w[7:0];
    return w;
endfunction

function automatic logic [7:0] widen(input logic [4:0] c);
    return 8'(c * 8 + c / 4);
endfunction

function automatic logic [7:0] player(input logic [7:0] joy, input logic st);
    return {st, joy[6], joy[5], joy[4], joy[0], joy[1], joy[2], joy[3]};
endfunction

function automatic logic [7:0] port_value(input logic [2:0] off);
    case (off)
        3'd0:    return dswa;
        3'd1:    return dswb;
        3'd2:    return player(joystick_p1, start[0]);
        3'd3:    return player(joystick_p2, start[1]);
        3'd4:    return {4'b0000, coin[1], coin[0], 2'b00};
        default: return 8'h00;
    endcase
endfunction

// SDRAM cycles and palette reads hold DTACK off on the first clock
function automatic logic delays_dtack();
    logic [23:0] byte_a;
    byte_a = {cpu_addr, 1'b0};
    if (cpu_fc == 3'b111) return 1'b0;
    if (byte_a < 24'h110000) return 1'b1;
    return cpu_rw && byte_a >= 24'h200000 && byte_a < 24'h202000;
endfunction

////////////////////////////////////////
// Completed bus cycle

task automatic complete_cycle();
    logic [23:0]           byte_a;
    logic [SDR_ADDR_W-1:0] exp_addr;
    logic [15:0]           old_w;
    int                    key;
    byte_a = {cpu_addr, 1'b0};
    was_sdram = 1'b0;
    if (cpu_fc == 3'b111) begin
        // Acknowledge cycles only touch the interrupt model
    end else if (byte_a < 24'h100000) begin
        was_sdram = 1'b1;
        exp_addr = ROM_SDR + 27'(byte_a);
        check_value("rom sdr_addr", 32'(exp_addr), 32'(sdr_addr));
        check_value("rom sdr_rw", 32'(1'b1), 32'(sdr_rw));
        check_value("rom sdr_be", 32'(cpu_ds_n ^ 2'b11), 32'(sdr_be));
        check_value("rom data", 32'(exp_addr[15:0] ^ 16'hffff), 32'(cpu_din));
    end else if (byte_a < 24'h110000) begin
        was_sdram = 1'b1;
        exp_addr = WORK_SDR + 27'(byte_a - 24'h100000);
        key = int'(cpu_addr);
        old_w = work_model.exists(key) ? work_model[key] : 16'h0000;
        check_value("work sdr_addr", 32'(exp_addr), 32'(sdr_addr));
        check_value("work sdr_rw", 32'(cpu_rw), 32'(sdr_rw));
        check_value("work sdr_be", 32'(cpu_ds_n ^ 2'b11), 32'(sdr_be));
        if (!cpu_rw) begin
            check_value("work sdr_data", 32'(cpu_dout), 32'(sdr_data));
            work_model[key] = merge(old_w, cpu_dout, cpu_ds_n);
        end else begin
            check_value("work data", 32'(old_w), 32'(cpu_din));
        end
    end else if (byte_a >= 24'h200000 && byte_a < 24'h202000) begin
        key = int'(cpu_addr[11:0]);
        old_w = pal_model.exists(key) ? pal_model[key].raw : 16'h0000;
        if (!cpu_rw) begin
            pal_model[key].raw = merge(old_w, cpu_dout, cpu_ds_n);
        end else begin
            check_value("palette data", 32'(old_w), 32'(cpu_din));
        end
    end else if (byte_a >= 24'h300000 && byte_a < 24'h300010) begin
        check_value("input port", 32'({8'h00, ~port_value(cpu_addr[2:0])}), 32'(cpu_din));
    end else if (cpu_rw) begin
        check_value("unmapped data", 32'h0, 32'(cpu_din));
    end
endtask

////////////////////////////////////////
// Sampling on each rising edge

always @(posedge clk) begin
    if (reset) begin
        in_cycle = 1'b0;
        done = 1'b0;
        toggles = 0;
        req_last = sdr_req;
        vbl_pend = 1'b0;
        dma_pend = 1'b0;
        pix1_valid = 1'b0;
        pix2_valid = 1'b0;
    end else begin
        check_value("ipl_n", 32'(dma_pend ? 3'b001 : vbl_pend ? 3'b010 : 3'b111),
                    32'(ipl_n));

        if (pix2_valid) begin
            check_value("pixel rgb", 32'(pix2_rgb), 32'({red, green, blue}));
        end
        pix2_valid = pix1_valid;
        pix2_rgb = pix1_rgb;
        pix1_valid = ce_pixel && pal_model.exists(int'(pixel_index));
        if (pix1_valid) begin
            pix1_rgb = {widen(pal_model[int'(pixel_index)].f.red),
                        widen(pal_model[int'(pixel_index)].f.green),
                        widen(pal_model[int'(pixel_index)].f.blue)};
        end

        if (sdr_req != req_last) toggles++;
        req_last = sdr_req;

        if (cpu_ds_n == 2'b11) begin
            check_value("dtack_n while idle", 32'h1, 32'(dtack_n));
            if (in_cycle) begin
                check_value("sdram requests in cycle", 32'(was_sdram),
                            32'(toggles - toggles_start));
            end
            in_cycle = 1'b0;
            done = 1'b0;
        end else begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                toggles_start = toggles;
                check_value("dtack_n at cycle start", 32'(delays_dtack()), 32'(dtack_n));
            end
            if (!dtack_n && !done) begin
                done = 1'b1;
                complete_cycle();
            end
        end

        // Edges set a level, acknowledge clears it
        if (vbl_prev && !vblank_n) vbl_pend = 1'b1;
        if (!dma_prev && dma_n) dma_pend = 1'b1;
        if (cpu_ds_n != 2'b11 && cpu_fc == 3'b111 && !cpu_ds_n[0]) begin
            if (cpu_addr[2:0] == 3'd5) vbl_pend = 1'b0;
            if (cpu_addr[2:0] == 3'd6) dma_pend = 1'b0;
        end
    end
    vbl_prev = vblank_n;
    dma_prev = dma_n;
end

endmodule

// ==== verification/tb_f2.sv ====
`timescale 1ns/1ps

module tb_f2 import f2_pkg::*; ();

localparam logic [SDR_ADDR_W-1:0] ROM_SDR  = 27'h0000000;
localparam logic [SDR_ADDR_W-1:0] WORK_SDR = 27'h0400000;

logic                  clk;
logic                  reset;
logic [CPU_ADDR_W-1:0] cpu_addr;
logic [1:0]            cpu_ds_n;
logic                  cpu_rw;
logic [2:0]            cpu_fc;
logic [15:0]           cpu_dout;
logic [15:0]           cpu_din;
logic                  dtack_n;
logic [2:0]            ipl_n;
logic [SDR_ADDR_W-1:0] sdr_addr;
logic [15:0]           sdr_data;
logic [1:0]            sdr_be;
logic                  sdr_rw;
logic                  sdr_req;
logic [15:0]           sdr_q = 16'h0000;
logic                  sdr_ack = 1'b0;
logic                  ce_pixel;
logic [PAL_ADDR_W-1:0] pixel_index;
logic                  vblank_n;
logic                  dma_n;
logic [7:0]            red;
logic [7:0]            green;
logic [7:0]            blue;
logic [7:0]            joystick_p1;
logic [7:0]            joystick_p2;
logic [1:0]            start;
logic [1:0]            coin;
logic [7:0]            dswa;
logic [7:0]            dswb;
int                    checks;
int                    errors;
int                    errors_before;
int                    resp_wait;
logic [15:0]           sdr_mem [int];

f2_main_bus #(
    .CPU_ROM_SDR_BASE  (ROM_SDR),
    .WORK_RAM_SDR_BASE (WORK_SDR)
) i_f2_main_bus (.*);

f2_checker #(.ROM_SDR(ROM_SDR), .WORK_SDR(WORK_SDR)) i_f2_checker (.*);

bind f2_main_bus f2_asserts i_f2_asserts (
    .clk, .reset, .sdr_req, .sdr_ack, .sdr_addr, .ipl_n
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

////////////////////////////////////////
// SDRAM responder

always @(negedge clk) begin
    if (reset) begin
        resp_wait = 0;
    end else if (sdr_req != sdr_ack) begin
        if (resp_wait == 0) begin
            resp_wait = int'($urandom_range(1, 8));
        end else if (resp_wait > 1) begin
            resp_wait--;
        end else begin
            resp_wait = 0;
            if (sdr_addr < WORK_SDR) begin
                sdr_q = ~sdr_addr[15:0];
            end else if (sdr_rw) begin
                sdr_q = sdr_mem.exists(int'(sdr_addr)) ? sdr_mem[int'(sdr_addr)] : 16'h0000;
            end else begin
                if (!sdr_mem.exists(int'(sdr_addr))) sdr_mem[int'(sdr_addr)] = 16'h0000;
                if (sdr_be[1]) sdr_mem[int'(sdr_addr)][15:8] = sdr_data[15:8];
                if (sdr_be[0]) sdr_mem[int'(sdr_addr)][7:0] = sdr_data[7:0];
            end
            sdr_ack = sdr_req;
        end
    end
end

////////////////////////////////////////
// Bus master

// Called on a falling edge, returns on one with the strobes high
task automatic bus_cycle(input logic [CPU_ADDR_W-1:0] addr, input logic [1:0] ds,
                         input logic rw, input logic [2:0] fc, input logic [15:0] data);
    int n;
    cpu_addr = addr;
    cpu_rw = rw;
    cpu_fc = fc;
    cpu_dout = data;
    cpu_ds_n = ds;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (dtack_n && n < 200);
    if (dtack_n) begin
        $display("DTACK never came for the cycle at word address %h", addr);
        $display("TEST FAILED");
        $finish;
    end
    @(posedge clk);
    @(negedge clk);
    cpu_ds_n = 2'b11;
    @(negedge clk);
endtask

task automatic wait_ipl(input logic [2:0] want);
    int n;
    n = 0;
    while (ipl_n !== want && n < 50) begin
        @(negedge clk);
        n++;
    end
    if (ipl_n !== want) begin
        $display("ipl_n did not reach %b within 50 cycles", want);
        $display("TEST FAILED");
        $finish;
    end
endtask

task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, errors - errors_before);
    errors_before = errors;
endtask

initial begin
    logic [CPU_ADDR_W-1:0] addrs [$];
    logic [PAL_ADDR_W-1:0] idx [$];
    void'($urandom(55254));
    reset = 1'b1;
    cpu_addr = '0;
    cpu_ds_n = 2'b11;
    cpu_rw = 1'b1;
    cpu_fc = 3'b101;
    cpu_dout = '0;
    ce_pixel = 1'b0;
    pixel_index = '0;
    vblank_n = 1'b1;
    dma_n = 1'b1;
    joystick_p1 = '0;
    joystick_p2 = '0;
    start = '0;
    coin = '0;
    dswa = '0;
    dswb = '0;
    errors_before = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    for (int i = 0; i < 16; i++) begin
        addrs.push_back(23'h080000 + 23'($urandom_range(0, 31)));
        bus_cycle(addrs[i], 2'($urandom_range(0, 2)), 1'b0, 3'b101, 16'($urandom));
    end
    foreach (addrs[i]) bus_cycle(addrs[i], 2'b00, 1'b1, 3'b101, 16'h0000);
    report_test("work RAM");

    for (int i = 0; i < 12; i++) begin
        bus_cycle(23'($urandom_range(0, 23'h07ffff)), 2'b00, 1'b1, 3'b110, 16'h0000);
    end
    report_test("program ROM");

    for (int i = 0; i < 12; i++) begin
        idx.push_back(12'($urandom));
        bus_cycle(23'h100000 + 23'(idx[i]), 2'b00, 1'b0, 3'b101, 16'($urandom));
    end
    for (int i = 0; i < 6; i++) begin
        bus_cycle(23'h100000 + 23'(idx[i]), 2'($urandom_range(1, 2)), 1'b0, 3'b101,
                  16'($urandom));
    end
    foreach (idx[i]) bus_cycle(23'h100000 + 23'(idx[i]), 2'b00, 1'b1, 3'b101, 16'h0000);
    for (int i = 0; i < 40; i++) begin
        ce_pixel = 1'($urandom);
        pixel_index = idx[$urandom_range(0, 11)];
        @(negedge clk);
    end
    ce_pixel = 1'b0;
    repeat (3) @(negedge clk);
    report_test("palette");

    for (int i = 0; i < 16; i++) begin
        joystick_p1 = 8'($urandom);
        joystick_p2 = 8'($urandom);
        start = 2'($urandom);
        coin = 2'($urandom);
        dswa = 8'($urandom);
        dswb = 8'($urandom);
        bus_cycle(23'h180000 + 23'(i % 8), 2'b00, 1'b1, 3'b101, 16'h0000);
    end
    report_test("input ports");

    // VBL first, then DMA end on top of it
    vblank_n = 1'b0;
    wait_ipl(3'b010);
    dma_n = 1'b0;
    @(negedge clk);
    dma_n = 1'b1;
    wait_ipl(3'b001);
    vblank_n = 1'b1;
    bus_cycle({20'hfffff, DMA_LEVEL}, 2'b10, 1'b1, 3'b111, 16'h0000);
    wait_ipl(3'b010);
    bus_cycle({20'hfffff, VBL_LEVEL}, 2'b10, 1'b1, 3'b111, 16'h0000);
    wait_ipl(3'b111);
    report_test("interrupts");

    for (int i = 0; i < 12; i++) begin
        if (i % 2 == 0) begin
            bus_cycle(23'($urandom_range(23'h0c0000, 23'h0fffff)), 2'b00, 1'b1, 3'b101, 16'h0);
        end else begin
            bus_cycle(23'($urandom_range(23'h200000, 23'h3fffff)), 2'b00, 1'b1, 3'b101, 16'h0);
        end
    end
    report_test("unmapped");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

// ==== sources.f ====
verilog/f2_pkg.sv
verilog/io_ports.sv
verilog/interrupt_ctrl.sv
verilog/palette.sv
verilog/sdram_bridge.sv
verilog/bus_decoder.sv
verilog/f2_main_bus.sv
verification/f2_asserts.sv
verification/f2_checker.sv
verification/tb_f2.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_f2 -o tb_f2 \
    && ./obj_dir/tb_f2 > sim.log 2>&1 \
    || { echo "build or simulation aborted"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^TEST OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
